/* sim.f */
+incdir+rtl
rtl/cart_pkg.sv
rtl/rom_header_detect.sv
rtl/cheat_code_assembler.sv
rtl/backup_sequencer.sv
rtl/cart_loader_top.sv
sim/tb_cart_loader.sv

/* Makefile */
# Verilator simulation of the cartridge loader

all: run

obj_dir/Vtb_cart_loader: sim.f rtl/*.sv rtl/*.svh sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cart_loader

run: obj_dir/Vtb_cart_loader
	./obj_dir/Vtb_cart_loader 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module tb_cart_loader

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* sim/tb_cart_loader.sv */
// Testbench for the cartridge loader
// Clock, reset, LFSR stimulus and an SD host model with the ack handshake
// Reference functions for header type, masks and sector count
// Header, cheat code and backup RAM transfer tests under a cycle limit

`timescale 1ns/1ps

`include "cart_settings.svh"

module tb_cart_loader import cart_pkg::*; ();

	// Five tests of at most about 2000 cycles each, doubled for margin
	localparam int test_count  = 5;
	localparam int test_cycles = 2000;
	localparam int max_cycles  = 2 * test_count * test_cycles;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	logic                       ioctl_download;
	logic [7:0]                 ioctl_index;
	logic                       ioctl_wr;
	logic [`CART_ADDR_W-1:0]    ioctl_addr;
	logic [`CART_DATA_W-1:0]    ioctl_dout;
	header_mode_t               header_mode;
	logic                       img_mounted;
	logic                       img_readonly;
	logic                       img_size_nonzero;
	logic                       bsram_write;
	logic                       osd_open;
	logic                       load_req;
	logic                       save_req;
	logic                       autosave;
	logic                       sd_ack;

	logic [7:0]                 rom_type;
	logic                       rom_region;
	logic [`CART_MASK_W-1:0]    rom_mask;
	logic [`CART_MASK_W-1:0]    ram_mask;
	logic [`CART_FIELD_W-1:0]   code_flags;
	logic [`CART_FIELD_W-1:0]   code_addr;
	logic [`CART_FIELD_W-1:0]   code_compare;
	logic [`CART_FIELD_W-1:0]   code_replace;
	logic                       code_load;
	logic                       code_reset;
	logic [`CART_LBA_W-1:0]     sd_lba;
	logic                       sd_rd;
	logic                       sd_wr;
	logic                       bk_busy;
	logic                       bk_loading;
	logic                       bk_pending;
	logic                       bk_enabled;
	logic                       led_user;

	logic [31:0] lfsr = 32'h9db6_0013;
	int          errors = 0;
	int          cycle_count = 0;
	int          load_count = 0;
	logic        reset_seen = 1'b0;

	// Sectors seen by the SD host, direction 1 for a write
	logic [31:0] lba_log[$];
	logic        dir_log[$];

	cart_loader_top dut_i (.*);

	always #4 clk_sys = ~clk_sys;

	//======================================================================
	// Random numbers and reference model
	//======================================================================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		int          k;
		r = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [7:0] expected_type(input header_mode_t mode,
			input logic [15:0] word0);
		case (mode)
			HDR_AUTO:    return word0[15:8];
			HDR_HIROM:   return 8'd1;
			HDR_EXHIROM: return 8'd2;
			default:     return 8'd0;
		endcase
	endfunction

	// ROM mask in the upper half, RAM mask in the lower half
	function automatic logic [47:0] expected_masks(input header_mode_t mode,
			input logic [15:0] word0, input logic [3:0] hdr_rom, input logic [3:0] hdr_ram);
		logic [3:0]  rom_sz;
		logic [3:0]  ram_sz;
		logic [63:0] rom_m;
		logic [63:0] ram_m;
		rom_sz = `CART_DEFAULT_ROM_SIZE;
		ram_sz = 4'd0;
		if (mode == HDR_AUTO && word0[7:0] != 8'd0) begin
			rom_sz = word0[3:0];
			ram_sz = word0[7:4];
		end else if (mode == HDR_LOROM || mode == HDR_HIROM || mode == HDR_EXHIROM) begin
			rom_sz = hdr_rom;
			ram_sz = hdr_ram;
		end
		// 1 KB doubled per size step, saturating at the 24-bit space
		rom_m = (64'd1 << (10 + rom_sz)) - 64'd1;
		ram_m = (ram_sz == 4'd0) ? 64'd0 : (64'd1 << (10 + ram_sz)) - 64'd1;
		return {rom_m[23:0], ram_m[23:0]};
	endfunction

	function automatic logic [24:0] header_addr(input header_mode_t mode);
		case (mode)
			HDR_HIROM:   return {1'b0, `CART_HIROM_HDR};
			HDR_EXHIROM: return {1'b0, `CART_EXHIROM_HDR};
			default:     return {1'b0, `CART_LOROM_HDR};
		endcase
	endfunction

	//======================================================================
	// Stimulus and checking tasks
	//======================================================================

	task automatic compare_value(input string name, input string field,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Error %s %s: expected %0h, actual %0h", name, field, expected, actual);
		end
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
	endtask

	// Idle tail so masks and the backup enable settle before the end
	task automatic end_download();
		repeat (4) @(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic load_cart(input header_mode_t mode, input logic [15:0] word0,
			input logic [15:0] word2, input logic [3:0] hdr_rom, input logic [3:0] hdr_ram);
		logic [31:0] fill;
		start_download(8'h00);
		header_mode <= mode;
		write_word(25'd0, word0);
		write_word(25'd2, word2);
		if (mode == HDR_LOROM || mode == HDR_HIROM || mode == HDR_EXHIROM) begin
			fill = random_bits(24);
			write_word(header_addr(mode), {fill[11:8], hdr_rom, fill[7:0]});
			write_word(header_addr(mode) + 25'd2, {fill[23:12], hdr_ram});
		end
		end_download();
	endtask

	task automatic check_header(input string name, input header_mode_t mode,
			input logic [15:0] word0, input logic [15:0] word2,
			input logic [3:0] hdr_rom, input logic [3:0] hdr_ram);
		logic [47:0] masks;
		masks = expected_masks(mode, word0, hdr_rom, hdr_ram);
		@(negedge clk_sys);
		compare_value(name, "rom_type", expected_type(mode, word0), rom_type);
		compare_value(name, "rom_region", word2[8], rom_region);
		compare_value(name, "rom_mask", masks[47:24], rom_mask);
		compare_value(name, "ram_mask", masks[23:0], ram_mask);
	endtask

	// Waits for bk_busy to rise and fall, watching bk_loading meanwhile
	task automatic wait_transfer(input string name, input logic loading);
		int n;
		int bad;
		n = 0;
		bad = 0;
		@(negedge clk_sys);
		while (!bk_busy && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (!bk_busy) begin
			errors++;
			$display("%s: the backup transfer never started", name);
		end
		n = 0;
		while (bk_busy && n < test_cycles) begin
			if (bk_loading !== loading)
				bad++;
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy) begin
			errors++;
			$display("%s: the backup transfer did not finish", name);
		end
		if (bad != 0)
			compare_value(name, "bad bk_loading cycles", 0, bad);
	endtask

	task automatic check_transfer(input string name, input logic is_write, input int sectors);
		int k;
		compare_value(name, "sector count", sectors, lba_log.size());
		for (k = 0; k < lba_log.size(); k++) begin
			compare_value(name, $sformatf("lba of sector %0d", k), k, lba_log[k]);
			compare_value(name, $sformatf("write flag of sector %0d", k), is_write, dir_log[k]);
		end
	endtask

	//======================================================================
	// SD host model and monitors
	//======================================================================

	initial begin : sd_host_model
		int delay;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba_log.push_back(sd_lba);
				dir_log.push_back(sd_wr);
				delay = 3 + int'(random_bits(2));
				repeat (delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (2) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (code_load)
			load_count = load_count + 1;
		if (code_reset && ioctl_download && ioctl_index != `CART_CODE_INDEX)
			reset_seen = 1'b1;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the tests did not complete", max_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//======================================================================
	// Test sequence
	//======================================================================

	initial begin : run_tests
		logic [15:0]  w0;
		logic [15:0]  w2;
		logic [3:0]   hdr_rom;
		logic [3:0]   hdr_ram;
		logic [15:0]  words[8];
		logic [47:0]  masks;
		header_mode_t mode;
		int           sectors;
		int           i;
		int           flagged;

		reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		header_mode = HDR_AUTO;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nonzero = 1'b0;
		bsram_write = 1'b0;
		osd_open = 1'b0;
		load_req = 1'b0;
		save_req = 1'b0;
		autosave = 1'b0;
		sd_ack = 1'b0;

		repeat (5) @(posedge clk_sys);
		reset <= 1'b1;
		@(negedge clk_sys);
		compare_value("reset", "status bits", 0,
			{sd_rd, sd_wr, bk_busy, bk_loading, bk_pending, bk_enabled, code_load});

		// Auto header from word 0
		w0 = random_bits(16);
		w0[0] = 1'b1;
		w2 = random_bits(16);
		load_cart(HDR_AUTO, w0, w2, 4'd0, 4'd0);
		check_header("auto_header", HDR_AUTO, w0, w2, 4'd0, 4'd0);

		// Forced mappings ignore the size byte at address 0
		for (i = 0; i < 3; i++) begin
			mode = header_mode_t'(3'(int'(HDR_LOROM) + i));
			w0 = random_bits(16);
			w0[0] = 1'b1;
			w2 = random_bits(16);
			hdr_rom = random_bits(4);
			hdr_ram = random_bits(4);
			load_cart(mode, w0, w2, hdr_rom, hdr_ram);
			check_header($sformatf("forced_%s", mode.name()), mode, w0, w2, hdr_rom, hdr_ram);
		end

		// Cheat code in slot order
		load_count = 0;
		start_download(`CART_CODE_INDEX);
		for (i = 0; i < 8; i++) begin
			words[i] = random_bits(16);
			write_word(25'(2 * i), words[i]);
		end
		end_download();
		@(negedge clk_sys);
		compare_value("cheat_code", "code_load pulses", 1, load_count);
		compare_value("cheat_code", "code_flags", {words[1], words[0]}, code_flags);
		compare_value("cheat_code", "code_addr", {words[3], words[2]}, code_addr);
		compare_value("cheat_code", "code_compare", {words[5], words[4]}, code_compare);
		compare_value("cheat_code", "code_replace", {words[7], words[6]}, code_replace);
		if (!reset_seen) begin
			errors++;
			$display("cheat_code: code_reset never went high during a cartridge download");
		end

		// Save of a cartridge with RAM size 1
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_readonly <= 1'b0;
		img_size_nonzero <= 1'b0;
		autosave <= 1'b1;
		w0 = random_bits(16);
		w0[7:4] = 4'h1;
		w2 = random_bits(16);
		masks = expected_masks(HDR_AUTO, w0, 4'd0, 4'd0);
		sectors = int'(masks[23:0] >> 9) + 1;
		load_cart(HDR_AUTO, w0, w2, 4'd0, 4'd0);
		@(posedge clk_sys);
		bsram_write <= 1'b1;
		@(posedge clk_sys);
		bsram_write <= 1'b0;
		@(negedge clk_sys);
		compare_value("save", "bk_pending", 1, bk_pending);
		compare_value("save", "led_user", 1, led_user);
		lba_log.delete();
		dir_log.delete();
		@(posedge clk_sys);
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
		wait_transfer("save", 1'b0);
		check_transfer("save", 1'b1, sectors);
		compare_value("save", "bk_pending", 0, bk_pending);
		compare_value("save", "bk_busy", 0, bk_busy);

		// Load at the end of a download
		@(posedge clk_sys);
		autosave <= 1'b0;
		img_size_nonzero <= 1'b1;
		lba_log.delete();
		dir_log.delete();
		load_cart(HDR_AUTO, w0, w2, 4'd0, 4'd0);
		wait_transfer("auto_load", 1'b1);
		check_transfer("auto_load", 1'b0, sectors);

		// Read-only image keeps the backup disabled
		@(posedge clk_sys);
		img_readonly <= 1'b1;
		load_cart(HDR_AUTO, w0, w2, 4'd0, 4'd0);
		lba_log.delete();
		dir_log.delete();
		@(posedge clk_sys);
		load_req <= 1'b1;
		@(posedge clk_sys);
		load_req <= 1'b0;
		flagged = 0;
		for (i = 0; i < 20; i++) begin
			@(negedge clk_sys);
			if (bk_enabled || bk_busy)
				flagged++;
		end
		compare_value("read_only", "enabled or busy cycles", 0, flagged);
		compare_value("read_only", "sector requests", 0, lba_log.size());

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* rtl/cart_loader_top.sv */
// Cartridge loader top level
// Splits the host download into cartridge and cheat code streams
// Header detection, cheat assembly and backup RAM sequencing
// User LED for loading and unsaved backup writes

`timescale 1ns/1ps

`include "cart_settings.svh"

module cart_loader_top import cart_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic                       ioctl_wr,
	input  logic [`CART_ADDR_W-1:0]    ioctl_addr,
	input  logic [`CART_DATA_W-1:0]    ioctl_dout,
	input  header_mode_t               header_mode,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_size_nonzero,
	input  logic                       bsram_write,
	input  logic                       osd_open,
	input  logic                       load_req,
	input  logic                       save_req,
	input  logic                       autosave,
	input  logic                       sd_ack,
	output logic [7:0]                 rom_type,
	output logic                       rom_region,
	output logic [`CART_MASK_W-1:0]    rom_mask,
	output logic [`CART_MASK_W-1:0]    ram_mask,
	output logic [`CART_FIELD_W-1:0]   code_flags,
	output logic [`CART_FIELD_W-1:0]   code_addr,
	output logic [`CART_FIELD_W-1:0]   code_compare,
	output logic [`CART_FIELD_W-1:0]   code_replace,
	output logic                       code_load,
	output logic                       code_reset,
	output logic [`CART_LBA_W-1:0]     sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_pending,
	output logic                       bk_enabled,
	output logic                       led_user
);

	logic code_index;
	logic code_download;
	logic cart_download;

	// The all-ones index carries cheat codes, anything else is a cartridge
	assign code_index    = ioctl_index == `CART_CODE_INDEX;
	assign code_download = ioctl_download & code_index;
	assign cart_download = ioctl_download & ~code_index;

	assign led_user = cart_download | (autosave & bk_pending);

	rom_header_detect rom_header_detect_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.rom_type      (rom_type),
		.rom_region    (rom_region),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask)
	);

	cheat_code_assembler cheat_code_assembler_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.code_flags    (code_flags),
		.code_addr     (code_addr),
		.code_compare  (code_compare),
		.code_replace  (code_replace),
		.code_load     (code_load),
		.code_reset    (code_reset)
	);

	backup_sequencer backup_sequencer_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_download    (cart_download),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.ram_mask         (ram_mask),
		.bsram_write      (bsram_write),
		.osd_open         (osd_open),
		.load_req         (load_req),
		.save_req         (save_req),
		.autosave         (autosave),
		.sd_ack           (sd_ack),
		.sd_lba           (sd_lba),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.bk_busy          (bk_busy),
		.bk_loading       (bk_loading),
		.bk_pending       (bk_pending),
		.bk_enabled       (bk_enabled)
	);

endmodule

/* rtl/backup_sequencer.sv */
// Backup RAM transfer to and from the SD image
// Enable from the mounted image and the cartridge RAM mask
// Pending-write tracking for autosave
// Sector-by-sector load and save over the sd_ack rise/fall protocol

`timescale 1ns/1ps

`include "cart_settings.svh"

module backup_sequencer import cart_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     cart_download,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     img_size_nonzero,
	input  logic [`CART_MASK_W-1:0]  ram_mask,
	input  logic                     bsram_write,
	input  logic                     osd_open,
	input  logic                     load_req,
	input  logic                     save_req,
	input  logic                     autosave,
	input  logic                     sd_ack,
	output logic [`CART_LBA_W-1:0]   sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     bk_busy,
	output logic                     bk_loading,
	output logic                     bk_pending,
	output logic                     bk_enabled
);

	bk_state_t               state;
	logic                    old_download;
	logic                    old_load;
	logic                    old_save;
	logic                    old_ack;
	logic                    save_trig;
	logic                    auto_load;
	logic                    load_rise;
	logic                    save_rise;
	logic                    start;
	logic                    start_load;
	logic                    ack_rise;
	logic                    ack_fall;
	logic [`CART_LBA_W-1:0]  last_lba;
	logic                    last_sector;
	logic                    advance;

	//======================================================================
	// Transfer triggers
	//======================================================================

	// Manual save, or autosave once the menu is open with writes pending
	assign save_trig = save_req | (autosave & bk_pending & osd_open);

	assign auto_load  = old_download & ~cart_download & img_size_nonzero & bk_enabled;
	assign load_rise  = load_req & ~old_load & bk_enabled;
	assign save_rise  = save_trig & ~old_save & bk_enabled;
	assign start_load = auto_load | load_rise;
	assign start      = (state == BK_IDLE) & (start_load | save_rise);

	assign ack_rise = sd_ack & ~old_ack;
	assign ack_fall = old_ack & ~sd_ack;

	// Image holds one sector per 512 bytes of cartridge RAM
	assign last_lba = {{(`CART_LBA_W - `CART_MASK_W){1'b0}}, ram_mask >> `CART_SECTOR_SHIFT};
	assign last_sector = sd_lba >= last_lba;
	assign advance     = (state == BK_TRANSFER) & ack_fall & ~last_sector;

	assign bk_busy = state == BK_TRANSFER;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= load_req;
			old_save     <= save_trig;
			old_ack      <= sd_ack;
		end
	end

	//======================================================================
	// Enable and pending writes
	//======================================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_enabled <= 1'b0;
		end else begin
			if (!old_download && cart_download)
				bk_enabled <= 1'b0;
			// Save file is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly)
				bk_enabled <= |ram_mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset)
			bk_pending <= 1'b0;
		else if (bk_enabled && !osd_open && bsram_write)
			bk_pending <= 1'b1;
		else if (start)
			bk_pending <= 1'b0;
	end

	//======================================================================
	// Sector sequencing
	//======================================================================

	always_ff @(posedge clk_sys) begin
		if (start)
			sd_lba <= '0;
		else if (advance)
			sd_lba <= sd_lba + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (start) begin
						state      <= BK_TRANSFER;
						bk_loading <= start_load;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				BK_TRANSFER: begin
					if (ack_fall) begin
						if (last_sector) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	sd_req_exclusive: assert property (
		@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr)
	);

endmodule

/* rtl/cheat_code_assembler.sv */
// Cheat code assembly from the code download
// Eight 16-bit words fill flags, address, compare and replace
// One-cycle load strobe after the last word, reset request for the engine

`timescale 1ns/1ps

`include "cart_settings.svh"

module cheat_code_assembler import cart_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       code_download,
	input  logic                       cart_download,
	input  logic                       ioctl_wr,
	input  logic [`CART_ADDR_W-1:0]    ioctl_addr,
	input  logic [`CART_DATA_W-1:0]    ioctl_dout,
	output logic [`CART_FIELD_W-1:0]   code_flags,
	output logic [`CART_FIELD_W-1:0]   code_addr,
	output logic [`CART_FIELD_W-1:0]   code_compare,
	output logic [`CART_FIELD_W-1:0]   code_replace,
	output logic                       code_load,
	output logic                       code_reset
);

	logic       code_wr;
	code_slot_t slot;

	// Byte addressed stream, so the word slot sits in bits 3..1
	assign code_wr = code_download & ioctl_wr & ~ioctl_addr[0];
	assign slot    = code_slot_t'(ioctl_addr[3:1]);

	// New cartridge or first word of a new code list drops stored codes
	assign code_reset = cart_download | (code_download & ioctl_wr & (ioctl_addr == '0));

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (slot)
				FLAGS_LO: code_flags[15:0]    <= ioctl_dout;
				FLAGS_HI: code_flags[31:16]   <= ioctl_dout;
				ADDR_LO:  code_addr[15:0]     <= ioctl_dout;
				ADDR_HI:  code_addr[31:16]    <= ioctl_dout;
				CMP_LO:   code_compare[15:0]  <= ioctl_dout;
				CMP_HI:   code_compare[31:16] <= ioctl_dout;
				REPL_LO:  code_replace[15:0]  <= ioctl_dout;
				REPL_HI:  code_replace[31:16] <= ioctl_dout;
				default:  ;
			endcase
		end
	end

	// Last word completes the code
	always_ff @(posedge clk_sys) begin
		if (!reset)
			code_load <= 1'b0;
		else
			code_load <= code_wr && slot == REPL_HI;
	end

	code_load_single: assert property (
		@(posedge clk_sys) disable iff (!reset)
		code_load |=> !code_load
	);

endmodule

/* rtl/rom_header_detect.sv */
// ROM header detection
// Mapping type and region from the first words of the download
// ROM and RAM size nibbles, auto or from the forced mapping header
// Registered ROM and RAM address masks

`timescale 1ns/1ps

`include "cart_settings.svh"

module rom_header_detect import cart_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cart_download,
	input  logic                      ioctl_wr,
	input  logic [`CART_ADDR_W-1:0]   ioctl_addr,
	input  logic [`CART_DATA_W-1:0]   ioctl_dout,
	input  header_mode_t              header_mode,
	output logic [7:0]                rom_type,
	output logic                      rom_region,
	output logic [`CART_MASK_W-1:0]   rom_mask,
	output logic [`CART_MASK_W-1:0]   ram_mask
);

	// Smallest mask unit is 1 KB
	localparam logic [`CART_MASK_W-1:0] mask_unit = 1024;

	logic                    hdr_wr;
	logic                    hdr_forced;
	logic [`CART_ADDR_W-1:0] hdr_addr;
	logic [3:0]              rom_size;
	logic [3:0]              ram_size;

	assign hdr_wr = cart_download & ioctl_wr;

	// Location of the size byte in the forced modes
	always_comb begin
		hdr_forced = 1'b1;
		hdr_addr   = '0;
		case (header_mode)
			HDR_LOROM:   hdr_addr = {1'b0, `CART_LOROM_HDR};
			HDR_HIROM:   hdr_addr = {1'b0, `CART_HIROM_HDR};
			HDR_EXHIROM: hdr_addr = {1'b0, `CART_EXHIROM_HDR};
			default:     hdr_forced = 1'b0;
		endcase
	end

	//======================================================================
	// Header fields
	//======================================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
			rom_size   <= `CART_DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= `CART_DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Auto mode trusts a nonzero size byte at the start
				if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'd0) begin
					rom_size <= ioctl_dout[3:0];
					ram_size <= ioctl_dout[7:4];
				end
				case (header_mode)
					HDR_NONE,
					HDR_LOROM:   rom_type <= 8'd0;
					HDR_HIROM:   rom_type <= 8'd1;
					HDR_EXHIROM: rom_type <= 8'd2;
					default:     rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == `CART_ADDR_W'(2))
				rom_region <= ioctl_dout[8];

			// Forced mapping reads the sizes from the internal header
			if (hdr_forced && ioctl_addr == hdr_addr)
				rom_size <= ioctl_dout[11:8];
			if (hdr_forced && ioctl_addr == hdr_addr + 2'd2)
				ram_size <= ioctl_dout[3:0];
		end
	end

	//======================================================================
	// Address masks
	//======================================================================

	// One cycle behind the size registers
	always_ff @(posedge clk_sys) begin
		rom_mask <= (mask_unit << rom_size) - 1'b1;
		if (ram_size != 4'd0)
			ram_mask <= (mask_unit << ram_size) - 1'b1;
		else
			ram_mask <= '0;
	end

	// ROM decoding downstream relies on a contiguous low mask
	rom_mask_contiguous: assert property (
		@(posedge clk_sys) disable iff (!reset)
		(rom_mask & (rom_mask + 1'b1)) == '0
	);

endmodule

/* rtl/cart_pkg.sv */
// Types shared by the cartridge loader blocks
// Header detection mode, backup transfer state, cheat word slots

package cart_pkg;

	// ROM header handling, matches the menu option order
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	// Backup RAM transfer
	typedef enum logic {
		BK_IDLE     = 1'b0,
		BK_TRANSFER = 1'b1
	} bk_state_t;

	// Word positions inside one cheat download record
	typedef enum logic [2:0] {
		FLAGS_LO = 3'd0,
		FLAGS_HI = 3'd1,
		ADDR_LO  = 3'd2,
		ADDR_HI  = 3'd3,
		CMP_LO   = 3'd4,
		CMP_HI   = 3'd5,
		REPL_LO  = 3'd6,
		REPL_HI  = 3'd7
	} code_slot_t;

endpackage

/* rtl/cart_settings.svh */
// Shared widths and constants for the cartridge loader
// Download stream, mask and SD sector sizes
// Header byte locations for each forced mapping
// Defaults used when the header gives nothing usable

`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// Download stream
`define CART_ADDR_W         25
`define CART_DATA_W         16
`define CART_CODE_INDEX     8'hFF

// Cartridge memory masks and SD image
`define CART_MASK_W         24
`define CART_LBA_W          32
`define CART_SECTOR_SHIFT   9

// Cheat code word, four 32-bit fields plus the load bit
`define CART_CODE_W         129
`define CART_FIELD_W        ((`CART_CODE_W - 1) / 4)

// Copier header in front of the ROM image
`define CART_HDR_OFFSET     24'h000200

// Size byte per mapping, copier offset included; RAM size byte is 2 above
`define CART_LOROM_HDR      (24'h007FD6 + `CART_HDR_OFFSET)
`define CART_HIROM_HDR      (24'h00FFD6 + `CART_HDR_OFFSET)
`define CART_EXHIROM_HDR    (24'h40FFD6 + `CART_HDR_OFFSET)

`define CART_DEFAULT_ROM_SIZE 4'hC

`endif
